/* list.f */
src/lsu_isa_pkg.sv
src/axi_lite_pkg.sv
src/lsu_decode.sv
src/lsu_execute.sv
src/lsu_result.sv
src/lsu_top.sv
sim/axi_lite_mem.sv
sim/tb_lsu.sv

/* run.sh */
#!/bin/sh
# Build the LSU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_lsu -f list.f -o tb_lsu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_lsu 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^\*\* PASS \*\*$'; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* sim/tb_lsu.sv */
// LSU testbench: directed tests, response checker, shadow memory model and watchdog
`timescale 1ns/1ps

module tb_lsu
  import lsu_isa_pkg::*, axi_lite_pkg::*;
();

  logic          clk_i;
  logic          rst_ni;
  lsu_req_t      req_i;
  logic          req_valid_i;
  logic          req_ready_o;
  lsu_resp_t     resp_o;
  logic          resp_valid_o;
  axi_lite_req_t axi_req;
  axi_lite_rsp_t axi_rsp;

  logic [31:0] shadow [256];
  lsu_resp_t   exp_q [$];
  trans_id_t   next_tid;
  logic [31:0] rand_state;
  int unsigned cycle;
  int unsigned last_accept;
  int unsigned last_resp;

  lsu_top i_lsu_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .axi_o        (axi_req),
    .axi_i        (axi_rsp)
  );

  axi_lite_mem i_axi_lite_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .axi_i  (axi_req),
    .axi_o  (axi_rsp)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  task automatic check_equal(string name, logic [31:0] act, logic [31:0] exp);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
      $display("** FAIL **");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  // Predicts each result by the RISC-V rules and updates the shadow memory in issue order
  function automatic lsu_resp_t predict(lsu_op_e op, addr_t addr, xlen_t data, trans_id_t tid);
    lsu_resp_t   r;
    int unsigned size;
    logic        st;
    logic        misal;
    xlen_t       val;
    r          = '0;
    r.trans_id = tid;
    st         = (op == SB) || (op == SH) || (op == SW);
    size       = (op == LB || op == LBU || op == SB) ? 1 : (op == LW || op == SW) ? 4 : 2;
    misal      = (size == 2 && addr[0]) || (size == 4 && addr[1:0] != 2'b00);
    if (misal || addr >= 32'h0000_0400) begin
      r.exception.valid = 1'b1;
      r.exception.tval  = addr;
      if (misal) begin
        r.exception.cause = st ? cause_t'(6) : cause_t'(4);
      end else begin
        r.exception.cause = st ? cause_t'(7) : cause_t'(5);
      end
    end else if (st) begin
      for (int b = 0; b < int'(size); b++) begin
        shadow[addr[9:2]][8*(int'(addr[1:0]) + b) +: 8] = data[8*b +: 8];
      end
    end else begin
      val = shadow[addr[9:2]] >> (8 * int'(addr[1:0]));
      case (op)
        LB:      r.result = xlen_t'($signed(val[7:0]));
        LH:      r.result = xlen_t'($signed(val[15:0]));
        LBU:     r.result = xlen_t'(val[7:0]);
        LHU:     r.result = xlen_t'(val[15:0]);
        default: r.result = val;
      endcase
    end
    return r;
  endfunction

  // --------------------
  // Driving and checking
  // --------------------
  // Presents one request and returns after the edge that accepts it
  task automatic send(lsu_op_e op, xlen_t base, xlen_t imm, xlen_t data);
    exp_q.push_back(predict(op, base + imm, data, next_tid));
    req_i.op         = op;
    req_i.operand_a  = base;
    req_i.imm        = imm;
    req_i.store_data = data;
    req_i.trans_id   = next_tid;
    req_valid_i      = 1'b1;
    next_tid         = next_tid + 3'd1;
    while (!req_ready_o) begin
      @(posedge clk_i);
      #1;
    end
    last_accept = cycle;
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic access(lsu_op_e op, xlen_t base, xlen_t imm, xlen_t data);
    send(op, base, imm, data);
    req_valid_i = 1'b0;
    wait_idle();
  endtask

  // Response checker on the falling edge
  always @(negedge clk_i) begin
    lsu_resp_t expected;
    if (rst_ni && resp_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("Response with trans_id %0d arrived with nothing outstanding",
                 resp_o.trans_id);
        $display("** FAIL **");
        $fatal(1, "Unexpected response");
      end else begin
        expected  = exp_q.pop_front();
        last_resp = cycle;
        check_equal("resp_o.trans_id", 32'(resp_o.trans_id), 32'(expected.trans_id));
        check_equal("resp_o.result", resp_o.result, expected.result);
        check_equal("resp_o.exception.valid", 32'(resp_o.exception.valid),
                    32'(expected.exception.valid));
        if (expected.exception.valid) begin
          check_equal("resp_o.exception.cause", 32'(resp_o.exception.cause),
                      32'(expected.exception.cause));
          check_equal("resp_o.exception.tval", resp_o.exception.tval,
                      expected.exception.tval);
        end
      end
    end
  end

  // --------------------
  // Directed tests
  // --------------------
  // Issue side ready, no result and a quiet bus once reset is released
  task automatic idle_after_reset();
    check_equal("req_ready_o", 32'(req_ready_o), 32'd1);
    check_equal("resp_valid_o", 32'(resp_valid_o), 32'd0);
    check_equal("axi_o.aw_valid", 32'(axi_req.aw_valid), 32'd0);
    check_equal("axi_o.w_valid", 32'(axi_req.w_valid), 32'd0);
    check_equal("axi_o.b_ready", 32'(axi_req.b_ready), 32'd0);
    check_equal("axi_o.ar_valid", 32'(axi_req.ar_valid), 32'd0);
    check_equal("axi_o.r_ready", 32'(axi_req.r_ready), 32'd0);
  endtask

  task automatic store_then_load();
    access(SW, 32'h0000_0100, 32'h0000_0020, 32'hdead_beef);
    access(LW, 32'h0000_0140, 32'hffff_ffe0, 32'h0);
  endtask

  task automatic byte_half_lanes();
    xlen_t data;
    for (int off = 0; off < 4; off++) begin
      data = {24'hcafe00, off[0] ? 8'h9a : 8'h5a} + xlen_t'(off);
      access(SB, 32'h0000_0200, xlen_t'(off), data);
      access(LW, 32'h0000_0204, 32'hffff_fffc, 32'h0);
      access(LB, 32'h0000_0200 + xlen_t'(off), 32'h0, 32'h0);
      access(LBU, 32'h0000_01f0, xlen_t'(16 + off), 32'h0);
    end
    for (int off = 0; off < 4; off += 2) begin
      data = (off == 0) ? 32'h1111_7bcd : 32'h2222_8421;
      access(SH, 32'h0000_0210, xlen_t'(off), data);
      access(LW, 32'h0000_0210, 32'h0, 32'h0);
      access(LH, 32'h0000_0210, xlen_t'(off), 32'h0);
      access(LHU, 32'h0000_0200, xlen_t'(16 + off), 32'h0);
    end
  endtask

  task automatic misaligned_access();
    access(SW, 32'h0000_0300, 32'h0, 32'h1234_5678);
    access(LH, 32'h0000_0300, 32'h1, 32'h0);
    check_equal("misaligned load latency", last_resp - last_accept, 32'd3);
    access(SW, 32'h0000_02fe, 32'h4, 32'hffff_ffff);
    check_equal("misaligned store latency", last_resp - last_accept, 32'd3);
    access(LW, 32'h0000_0300, 32'h0, 32'h0);
  endtask

  task automatic bus_fault();
    access(LW, 32'h0000_0800, 32'h0, 32'h0);
    access(SW, 32'h0000_07f0, 32'h10, 32'h0bad_0bad);
  endtask

  // Valid stays high across the whole burst
  task automatic random_stream();
    logic [31:0] r;
    addr_t       addr;
    for (int i = 0; i < 20; i++) begin
      r    = next_rand();
      addr = 32'h0000_0380 | {26'b0, r[19:16], 2'b00};
      if (r[24]) begin
        send(SW, addr, 32'h0, next_rand());
      end else begin
        send(LW, addr, 32'h0, 32'h0);
      end
    end
    req_valid_i = 1'b0;
    wait_idle();
  endtask

  // Watchdog allows 40 cycles for each of the 52 requests
  initial begin
    repeat (52 * 40) @(posedge clk_i);
    $display("Watchdog expired before the tests finished");
    $display("** FAIL **");
    $fatal(1, "Timeout");
  end

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    next_tid    = '0;
    rand_state  = 32'hbba0_3e65;
    cycle       = 0;
    last_accept = 0;
    last_resp   = 0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // Shadow starts from the memory's reset contents
    for (int i = 0; i < 256; i++) begin
      shadow[i[7:0]] = i_axi_lite_mem.mem[i[7:0]];
    end
    idle_after_reset();
    @(posedge clk_i);
    #1;
    store_then_load();
    byte_half_lanes();
    misaligned_access();
    bus_fault();
    random_stream();
    $display("** PASS **");
    $finish;
  end

endmodule

/* sim/axi_lite_mem.sv */
// AXI4-Lite slave memory model with random ready stalls and a SLVERR region
`timescale 1ns/1ps

module axi_lite_mem
  import axi_lite_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  axi_lite_req_t axi_i,
  output axi_lite_rsp_t axi_o
);

  // 256 words below 0x400, everything above answers SLVERR
  logic [31:0] mem [256];

  logic [31:0] lcg_q;
  logic [1:0]  wait_q;
  logic        aw_got_q;
  logic        w_got_q;
  axi_addr_t   aw_addr_q;
  axi_data_t   w_data_q;
  axi_strb_t   w_strb_q;
  logic        b_valid_q;
  axi_resp_t   b_resp_q;
  logic        r_valid_q;
  axi_data_t   r_data_q;
  axi_resp_t   r_resp_q;
  logic        aw_hs;
  logic        w_hs;
  logic        ar_hs;
  logic        pending;

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Reset contents, built from the full byte address of each word
  function automatic logic [31:0] fill_word(int unsigned idx);
    logic [31:0] a;
    a = idx << 2;
    return {a[15:0] ^ 16'h5aa5, a[15:0]};
  endfunction

  // --------------------
  // Handshakes
  // --------------------
  always_comb begin
    axi_o          = '0;
    axi_o.aw_ready = axi_i.aw_valid && !aw_got_q && !b_valid_q && (wait_q == 2'd0);
    axi_o.w_ready  = axi_i.w_valid && !w_got_q && !b_valid_q && (wait_q == 2'd0);
    axi_o.ar_ready = axi_i.ar_valid && !r_valid_q && (wait_q == 2'd0);
    axi_o.b_valid  = b_valid_q;
    axi_o.b_resp   = b_resp_q;
    axi_o.r_valid  = r_valid_q;
    axi_o.r_data   = r_data_q;
    axi_o.r_resp   = r_resp_q;
  end

  assign aw_hs   = axi_i.aw_valid && axi_o.aw_ready;
  assign w_hs    = axi_i.w_valid && axi_o.w_ready;
  assign ar_hs   = axi_i.ar_valid && axi_o.ar_ready;
  assign pending = (axi_i.aw_valid && !aw_got_q) || (axi_i.w_valid && !w_got_q) ||
                   (axi_i.ar_valid && !r_valid_q);

  // --------------------
  // Storage and responses
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 256; i++) begin
        mem[i[7:0]] <= fill_word(i);
      end
      lcg_q     <= 32'hbba0_3e65;
      wait_q    <= 2'd0;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      aw_addr_q <= '0;
      w_data_q  <= '0;
      w_strb_q  <= '0;
      b_valid_q <= 1'b0;
      b_resp_q  <= AXI_OKAY;
      r_valid_q <= 1'b0;
      r_data_q  <= '0;
      r_resp_q  <= AXI_OKAY;
    end else begin
      // New stall length after every address or data handshake
      if (aw_hs || w_hs || ar_hs) begin
        lcg_q  <= lcg_next(lcg_q);
        wait_q <= lcg_q[17:16];
      end else if (pending && wait_q != 2'd0) begin
        wait_q <= wait_q - 2'd1;
      end
      if (aw_hs) begin
        aw_got_q  <= 1'b1;
        aw_addr_q <= axi_i.aw_addr;
      end
      if (w_hs) begin
        w_got_q  <= 1'b1;
        w_data_q <= axi_i.w_data;
        w_strb_q <= axi_i.w_strb;
      end
      // Both halves of the write are in
      if (aw_got_q && w_got_q) begin
        aw_got_q  <= 1'b0;
        w_got_q   <= 1'b0;
        b_valid_q <= 1'b1;
        if (aw_addr_q < 32'h0000_0400) begin
          for (int b = 0; b < 4; b++) begin
            if (w_strb_q[b]) begin
              mem[aw_addr_q[9:2]][b*8 +: 8] <= w_data_q[b*8 +: 8];
            end
          end
          b_resp_q <= AXI_OKAY;
        end else begin
          b_resp_q <= AXI_SLVERR;
        end
      end
      if (b_valid_q && axi_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (ar_hs) begin
        r_valid_q <= 1'b1;
        if (axi_i.ar_addr < 32'h0000_0400) begin
          r_data_q <= mem[axi_i.ar_addr[9:2]];
          r_resp_q <= AXI_OKAY;
        end else begin
          r_data_q <= '0;
          r_resp_q <= AXI_SLVERR;
        end
      end
      if (r_valid_q && axi_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

endmodule

/* src/lsu_top.sv */
// Load/store unit top level connecting decode, execute and result
`timescale 1ns/1ps

module lsu_top
  import lsu_isa_pkg::*, axi_lite_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  // Issue side
  input  lsu_req_t      req_i,
  input  logic          req_valid_i,
  output logic          req_ready_o,
  // Result side
  output lsu_resp_t     resp_o,
  output logic          resp_valid_o,
  // Memory side
  output axi_lite_req_t axi_o,
  input  axi_lite_rsp_t axi_i
);

  lsu_dec_t  dec;
  logic      dec_valid;
  logic      dec_ready;
  lsu_done_t done;
  logic      done_valid;

  // --------------------
  // Stages
  // --------------------
  lsu_decode i_lsu_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .dec_o       (dec),
    .dec_valid_o (dec_valid),
    .dec_ready_i (dec_ready)
  );

  lsu_execute i_lsu_execute (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .dec_i        (dec),
    .dec_valid_i  (dec_valid),
    .dec_ready_o  (dec_ready),
    .axi_o        (axi_o),
    .axi_i        (axi_i),
    .done_o       (done),
    .done_valid_o (done_valid)
  );

  lsu_result i_lsu_result (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .done_i       (done),
    .done_valid_i (done_valid),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o)
  );

endmodule

/* src/lsu_result.sv */
// Result stage: load extraction with sign or zero extension, access faults, result register
`timescale 1ns/1ps

module lsu_result
  import lsu_isa_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  lsu_done_t done_i,
  input  logic      done_valid_i,
  output lsu_resp_t resp_o,
  output logic      resp_valid_o
);

  xlen_t     shifted;
  lsu_resp_t resp_d;
  lsu_resp_t resp_q;
  logic      valid_q;

  // Bring the addressed byte or halfword down to bit 0
  assign shifted = done_i.rdata >> {done_i.offset, 3'b000};

  always_comb begin
    resp_d.trans_id  = done_i.trans_id;
    resp_d.exception = done_i.exception;
    case (done_i.op)
      LB:      resp_d.result = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      LH:      resp_d.result = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      LW:      resp_d.result = shifted;
      LBU:     resp_d.result = {{(XLEN-8){1'b0}}, shifted[7:0]};
      LHU:     resp_d.result = {{(XLEN-16){1'b0}}, shifted[15:0]};
      // stores have no result value
      default: resp_d.result = '0;
    endcase

    // --------------------
    // Access faults
    // --------------------
    // Misalignment from decode wins, it never reached the bus
    if (!done_i.exception.valid && done_i.bus_err) begin
      resp_d.exception.valid = 1'b1;
      resp_d.exception.cause = is_store(done_i.op) ? CAUSE_ST_ACCESS
                                                   : CAUSE_LD_ACCESS;
      resp_d.exception.tval  = done_i.addr;
    end
    if (resp_d.exception.valid) begin
      resp_d.result = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= done_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done_valid_i) begin
      resp_q <= resp_d;
    end
  end

  assign resp_o       = resp_q;
  assign resp_valid_o = valid_q;

endmodule

/* src/lsu_execute.sv */
// Execute stage: AXI4-Lite master FSM doing one read or write per decoded item
`timescale 1ns/1ps

module lsu_execute
  import lsu_isa_pkg::*, axi_lite_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  // From decode
  input  lsu_dec_t      dec_i,
  input  logic          dec_valid_i,
  output logic          dec_ready_o,
  // AXI4-Lite master port
  output axi_lite_req_t axi_o,
  input  axi_lite_rsp_t axi_i,
  // Towards result
  output lsu_done_t     done_o,
  output logic          done_valid_o
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ,
    DONE
  } state_e;

  state_e   state_q;
  state_e   state_d;
  lsu_dec_t item_q;
  logic     addr_done_q;
  logic     data_done_q;
  xlen_t    rdata_q;
  logic     bus_err_q;
  logic     take;
  logic     aw_hs;
  logic     w_hs;
  logic     b_hs;
  logic     ar_hs;
  logic     r_hs;

  assign dec_ready_o = (state_q == IDLE);
  assign take        = dec_valid_i && dec_ready_o;

  // --------------------
  // Bus drive
  // --------------------
  always_comb begin
    axi_o         = '0;
    axi_o.aw_addr = item_q.addr;
    axi_o.w_data  = item_q.wdata;
    axi_o.w_strb  = item_q.be;
    axi_o.ar_addr = item_q.addr;
    case (state_q)
      WRITE: begin
        // AW and W go out together, B only once both were taken
        axi_o.aw_valid = !addr_done_q;
        axi_o.w_valid  = !data_done_q;
        axi_o.b_ready  = addr_done_q && data_done_q;
      end
      READ: begin
        axi_o.ar_valid = !addr_done_q;
        axi_o.r_ready  = addr_done_q;
      end
      default: ;
    endcase
  end

  assign aw_hs = axi_o.aw_valid && axi_i.aw_ready;
  assign w_hs  = axi_o.w_valid  && axi_i.w_ready;
  assign b_hs  = axi_o.b_ready  && axi_i.b_valid;
  assign ar_hs = axi_o.ar_valid && axi_i.ar_ready;
  assign r_hs  = axi_o.r_ready  && axi_i.r_valid;

  // --------------------
  // FSM
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (take) begin
          // Misaligned items skip the bus entirely
          if (dec_i.exception.valid) state_d = DONE;
          else if (is_store(dec_i.op)) state_d = WRITE;
          else state_d = READ;
        end
      end
      WRITE:   if (b_hs) state_d = DONE;
      READ:    if (r_hs) state_d = DONE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      addr_done_q <= 1'b0;
      data_done_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (take) begin
        addr_done_q <= 1'b0;
        data_done_q <= 1'b0;
      end else begin
        if (aw_hs || ar_hs) addr_done_q <= 1'b1;
        if (w_hs) data_done_q <= 1'b1;
      end
    end
  end

  // Item and captured bus response
  always_ff @(posedge clk_i) begin
    if (take) begin
      item_q    <= dec_i;
      rdata_q   <= '0;
      bus_err_q <= 1'b0;
    end
    if (b_hs) begin
      bus_err_q <= (axi_i.b_resp != AXI_OKAY);
    end
    if (r_hs) begin
      rdata_q   <= axi_i.r_data;
      bus_err_q <= (axi_i.r_resp != AXI_OKAY);
    end
  end

  // --------------------
  // Finished access
  // --------------------
  assign done_o.op        = item_q.op;
  assign done_o.offset    = item_q.addr[1:0];
  assign done_o.trans_id  = item_q.trans_id;
  assign done_o.addr      = item_q.addr;
  assign done_o.rdata     = rdata_q;
  assign done_o.bus_err   = bus_err_q;
  assign done_o.exception = item_q.exception;
  assign done_valid_o     = (state_q == DONE);

endmodule

/* src/lsu_decode.sv */
// Decode stage: address generation, byte enables, store lane placement, misalignment check
`timescale 1ns/1ps

module lsu_decode
  import lsu_isa_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // Issue side
  input  lsu_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  // Towards execute
  output lsu_dec_t dec_o,
  output logic     dec_valid_o,
  input  logic     dec_ready_i
);

  addr_t    addr;
  be_t      be;
  xlen_t    wdata;
  logic     misaligned;
  logic     accept;
  lsu_dec_t dec_d;
  lsu_dec_t dec_q;
  logic     valid_q;

  // --------------------
  // Address generation
  // --------------------
  // Two's complement add, so a negative immediate just wraps
  assign addr = req_i.operand_a + req_i.imm;

  // --------------------
  // Byte enables
  // --------------------
  always_comb begin
    be         = 4'b1111;
    misaligned = 1'b0;
    case (req_i.op)
      LB, LBU, SB: begin
        be = 4'b0001 << addr[1:0];
      end
      LH, LHU, SH: begin
        be         = 4'b0011 << addr[1:0];
        misaligned = addr[0];
      end
      default: begin
        // Word access
        be         = 4'b1111;
        misaligned = (addr[1:0] != 2'b00);
      end
    endcase
  end

  // Move store data up to the lanes picked by the low address bits
  assign wdata = req_i.store_data << {addr[1:0], 3'b000};

  // --------------------
  // Decoded item
  // --------------------
  always_comb begin
    dec_d.op                 = req_i.op;
    dec_d.addr               = addr;
    dec_d.be                 = be;
    dec_d.wdata              = wdata;
    dec_d.trans_id           = req_i.trans_id;
    dec_d.exception.valid    = misaligned;
    dec_d.exception.cause    = is_store(req_i.op) ? CAUSE_ST_MISALIGNED
                                                  : CAUSE_LD_MISALIGNED;
    dec_d.exception.tval     = addr;
    if (!misaligned) begin
      dec_d.exception.cause  = '0;
      dec_d.exception.tval   = '0;
    end
  end

  // Free slot, or the held item leaves this cycle
  assign req_ready_o = !valid_q || dec_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (dec_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_q <= dec_d;
    end
  end

  assign dec_o       = dec_q;
  assign dec_valid_o = valid_q;

endmodule

/* src/axi_lite_pkg.sv */
// AXI4-Lite widths, response codes and the master request and slave response structs
package axi_lite_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned AXI_ADDR_W = 32;
  localparam int unsigned AXI_DATA_W = 32;
  localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;
  localparam int unsigned AXI_RESP_W = 2;

  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [AXI_RESP_W-1:0] axi_resp_t;

  localparam axi_resp_t AXI_OKAY   = 2'b00;
  localparam axi_resp_t AXI_SLVERR = 2'b10;

  // --------------------
  // Channel bundles
  // --------------------
  // Master side: AW, W, B ready, AR, R ready
  typedef struct packed {
    logic      aw_valid;
    axi_addr_t aw_addr;
    logic      w_valid;
    axi_data_t w_data;
    axi_strb_t w_strb;
    logic      b_ready;
    logic      ar_valid;
    axi_addr_t ar_addr;
    logic      r_ready;
  } axi_lite_req_t;

  // Slave side
  typedef struct packed {
    logic      aw_ready;
    logic      w_ready;
    logic      b_valid;
    axi_resp_t b_resp;
    logic      ar_ready;
    logic      r_valid;
    axi_data_t r_data;
    axi_resp_t r_resp;
  } axi_lite_rsp_t;

endpackage

/* src/lsu_isa_pkg.sv */
// ISA-side widths, word types, load/store operations, exception causes and LSU structs
package lsu_isa_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned BE_W       = XLEN / 8;
  localparam int unsigned TRANS_ID_W = 3;
  localparam int unsigned CAUSE_W    = 4;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [XLEN-1:0]       addr_t;
  typedef logic [BE_W-1:0]       be_t;
  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [CAUSE_W-1:0]    cause_t;

  typedef enum logic [2:0] {
    LB, LH, LW, LBU, LHU, SB, SH, SW
  } lsu_op_e;

  // mcause encodings for the memory exceptions we raise
  localparam cause_t CAUSE_LD_MISALIGNED = cause_t'(4);
  localparam cause_t CAUSE_LD_ACCESS     = cause_t'(5);
  localparam cause_t CAUSE_ST_MISALIGNED = cause_t'(6);
  localparam cause_t CAUSE_ST_ACCESS     = cause_t'(7);

  // --------------------
  // Structs
  // --------------------
  typedef struct packed {
    lsu_op_e   op;
    xlen_t     operand_a;
    xlen_t     imm;
    xlen_t     store_data;
    trans_id_t trans_id;
  } lsu_req_t;

  typedef struct packed {
    logic   valid;
    cause_t cause;
    xlen_t  tval;
  } lsu_exc_t;

  typedef struct packed {
    trans_id_t trans_id;
    xlen_t     result;
    lsu_exc_t  exception;
  } lsu_resp_t;

  // Store data already sits on its byte lanes here
  typedef struct packed {
    lsu_op_e   op;
    addr_t     addr;
    be_t       be;
    xlen_t     wdata;
    trans_id_t trans_id;
    lsu_exc_t  exception;
  } lsu_dec_t;

  typedef struct packed {
    lsu_op_e    op;
    logic [1:0] offset;
    trans_id_t  trans_id;
    addr_t      addr;
    xlen_t      rdata;
    logic       bus_err;
    lsu_exc_t   exception;
  } lsu_done_t;

  function automatic logic is_store(lsu_op_e op);
    return op inside {SB, SH, SW};
  endfunction

endpackage
